/* hw/bcd_splitter.sv */
`timescale 1ns/1ns

module bcd_splitter (
    input  logic [calc_pkg::RESULT_WIDTH-1:0] result,
    output logic [calc_pkg::DIGIT_WIDTH-1:0]  led_tens,
    output logic [calc_pkg::DIGIT_WIDTH-1:0]  led_ones
);

    import calc_pkg::*;

    localparam int MAX_TENS = 9;

    logic [RESULT_WIDTH-1:0] decade_base;

    // Highest decade not above the result
    always_comb begin
        led_tens    = '0;
        decade_base = '0;
        for (int d = 1; d <= MAX_TENS; d++) begin
            if (result >= RESULT_WIDTH'(d * 10)) begin
                led_tens    = DIGIT_WIDTH'(d);
                decade_base = RESULT_WIDTH'(d * 10);
            end
        end
        led_ones = DIGIT_WIDTH'(result - decade_base);  // Remainder below 10
    end

endmodule

/* hw/calc_fsm.sv */
`timescale 1ns/1ns

module calc_fsm (
    input  logic                               time1Oms,
    input  logic                               reset,
    input  keypad_pkg::key_e                   key,
    output logic [calc_pkg::RESULT_WIDTH-1:0]  result,
    output logic                               point_time,
    output logic [calc_pkg::DIGIT_WIDTH-1:0]   led_sign
);

    import keypad_pkg::*;
    import calc_pkg::*;

    calc_state_e            state;
    calc_op_e               op;
    logic [DIGIT_WIDTH-1:0] operand_a;
    logic [DIGIT_WIDTH-1:0] operand_b;

    logic                    is_digit;
    logic [DIGIT_WIDTH-1:0]  digit;
    logic [RESULT_WIDTH-1:0] wide_a;
    logic [RESULT_WIDTH-1:0] wide_b;
    logic [RESULT_WIDTH-1:0] sum;
    logic [RESULT_WIDTH-1:0] diff_ab;
    logic [RESULT_WIDTH-1:0] diff_ba;
    logic [RESULT_WIDTH-1:0] product;

    // Digit value of a numeric key
    always_comb begin
        is_digit = 1'b1;
        case (key)
            K_0:     digit = 4'd0;
            K_1:     digit = 4'd1;
            K_2:     digit = 4'd2;
            K_3:     digit = 4'd3;
            K_4:     digit = 4'd4;
            K_5:     digit = 4'd5;
            K_6:     digit = 4'd6;
            K_7:     digit = 4'd7;
            K_8:     digit = 4'd8;
            K_9:     digit = 4'd9;
            default: begin
                is_digit = 1'b0;
                digit    = '0;
            end
        endcase
    end

    assign wide_a  = RESULT_WIDTH'(operand_a);
    assign wide_b  = RESULT_WIDTH'(operand_b);
    assign sum     = wide_a + wide_b;
    assign diff_ab = wide_a - wide_b;
    assign diff_ba = wide_b - wide_a;
    assign product = wide_a * wide_b;  // At most 81

    always_ff @(posedge time1Oms or negedge reset) begin
        if (!reset) begin
            state      <= S_ENTER_A;
            op         <= OP_NONE;
            operand_a  <= '0;
            operand_b  <= '0;
            result     <= '0;
            point_time <= 1'b1;
            led_sign   <= SIGN_BLANK;
        end else if (is_digit) begin
            case (state)
                S_ENTER_A: begin
                    operand_a <= digit;
                    result    <= RESULT_WIDTH'(digit);
                    led_sign  <= SIGN_BLANK;
                    state     <= S_HAVE_A;
                end
                S_ENTER_B: begin
                    operand_b <= digit;
                    result    <= RESULT_WIDTH'(digit);
                    state     <= S_HAVE_B;
                end
                default: ;  // Extra digits dropped
            endcase
        end else begin
            case (key)
                K_ADD, K_SUB, K_MUL: begin
                    if (state == S_HAVE_A) begin
                        state      <= S_ENTER_B;
                        point_time <= (key == K_ADD);  // Point lit only for plus
                        if (key == K_ADD) begin
                            op <= OP_ADD;
                        end else if (key == K_SUB) begin
                            op <= OP_SUB;
                        end else begin
                            op <= OP_MUL;
                        end
                    end
                end
                K_EQ: begin
                    case (op)
                        OP_ADD: begin
                            result   <= sum;
                            led_sign <= SIGN_BLANK;
                        end
                        OP_SUB: begin
                            if (operand_a >= operand_b) begin
                                result   <= diff_ab;
                                led_sign <= SIGN_BLANK;
                            end else begin
                                result   <= diff_ba;   // Magnitude, sign shown apart
                                led_sign <= SIGN_MINUS;
                            end
                        end
                        OP_MUL: begin
                            result   <= product;
                            led_sign <= SIGN_BLANK;
                        end
                        default: ;  // Nothing pending, keep display
                    endcase
                    point_time <= 1'b1;
                    op         <= OP_NONE;
                    state      <= S_ENTER_A;
                end
                K_CLR: begin
                    state      <= S_ENTER_A;
                    op         <= OP_NONE;
                    operand_a  <= '0;
                    operand_b  <= '0;
                    result     <= '0;
                    point_time <= 1'b1;
                    led_sign   <= SIGN_BLANK;
                end
                default: ;  // Y and idle scans
            endcase
        end
    end

endmodule

/* hw/calc_pkg.sv */
package calc_pkg;

    // One decimal digit, operand or display
    localparam int DIGIT_WIDTH = 4;

    // Largest result is 9 x 9 = 81
    localparam int RESULT_WIDTH = 7;

    // Sign digit codes for the display driver
    localparam logic [DIGIT_WIDTH-1:0] SIGN_MINUS = 4'd10;
    localparam logic [DIGIT_WIDTH-1:0] SIGN_BLANK = 4'd11;

    typedef enum logic [1:0] {
        S_ENTER_A = 2'd0,  // Waiting for first operand
        S_HAVE_A  = 2'd1,  // Waiting for operator
        S_ENTER_B = 2'd2,  // Waiting for second operand
        S_HAVE_B  = 2'd3   // Waiting for equals
    } calc_state_e;

    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2,
        OP_MUL  = 2'd3
    } calc_op_e;

endpackage

/* hw/calculator_top.sv */
`timescale 1ns/1ns

module calculator_top (
    input  logic                             time1Oms,
    input  logic                             reset,
    input  logic [keypad_pkg::SCAN_WIDTH-1:0] key_in,
    output logic [keypad_pkg::SCAN_WIDTH-1:0] key_out,
    output logic [keypad_pkg::LED_WIDTH-1:0]  led,
    output logic                             point_time,
    output logic [calc_pkg::DIGIT_WIDTH-1:0]  led_sign,
    output logic [calc_pkg::DIGIT_WIDTH-1:0]  led_tens,
    output logic [calc_pkg::DIGIT_WIDTH-1:0]  led_ones
);

    import keypad_pkg::*;
    import calc_pkg::*;

    key_e                    key;
    logic [RESULT_WIDTH-1:0] result;  // Binary value before decimal split

    key_scanner scanner_inst (
        .time1Oms (time1Oms),
        .reset    (reset),
        .key_out  (key_out)
    );

    key_decoder decoder_inst (
        .time1Oms (time1Oms),
        .reset    (reset),
        .key_in   (key_in),
        .key_out  (key_out),
        .key      (key),
        .led      (led)
    );

    calc_fsm fsm_inst (
        .time1Oms   (time1Oms),
        .reset      (reset),
        .key        (key),
        .result     (result),
        .point_time (point_time),
        .led_sign   (led_sign)
    );

    bcd_splitter splitter_inst (
        .result   (result),
        .led_tens (led_tens),
        .led_ones (led_ones)
    );

endmodule

/* hw/key_decoder.sv */
`timescale 1ns/1ns

module key_decoder (
    input  logic                             time1Oms,
    input  logic                             reset,
    input  logic [keypad_pkg::SCAN_WIDTH-1:0] key_in,
    input  logic [keypad_pkg::SCAN_WIDTH-1:0] key_out,
    output keypad_pkg::key_e                  key,
    output logic [keypad_pkg::LED_WIDTH-1:0]  led
);

    import keypad_pkg::*;

    localparam int POS_WIDTH = $clog2(SCAN_WIDTH);

    logic [POS_WIDTH-1:0] row_pos;
    logic [POS_WIDTH-1:0] col_pos;
    logic                 row_ok;
    logic                 col_ok;

    // Position of the single set bit in rows and columns
    always_comb begin
        row_pos = '0;
        col_pos = '0;
        for (int i = 0; i < SCAN_WIDTH; i++) begin
            if (key_in[i]) begin
                row_pos = POS_WIDTH'(i);
            end
            if (key_out[i]) begin
                col_pos = POS_WIDTH'(i);
            end
        end
        row_ok = $onehot(key_in);   // Two rows at once is a ghost
        col_ok = $onehot(key_out);
    end

    always_comb begin
        if (row_ok && col_ok) begin
            key = key_e'(KEY_WIDTH'({col_pos, row_pos}) + KEY_WIDTH'(1));
        end else begin
            key = K_NONE;
        end
    end

    always_ff @(posedge time1Oms or negedge reset) begin
        if (!reset) begin
            led <= LED_IDLE;
        end else if (key == K_NONE) begin
            led <= LED_IDLE;
        end else begin
            led <= LED_IDLE - LED_WIDTH'(key);  // 31 minus key index
        end
    end

endmodule

/* hw/key_scanner.sv */
`timescale 1ns/1ns

module key_scanner (
    input  logic                            time1Oms,
    input  logic                            reset,
    output logic [keypad_pkg::SCAN_WIDTH-1:0] key_out
);

    import keypad_pkg::*;

    localparam logic [SCAN_WIDTH-1:0] STROBE_INIT = SCAN_WIDTH'(1);

    logic [SCAN_WIDTH-1:0] strobe;

    always_ff @(posedge time1Oms or negedge reset) begin
        if (!reset) begin
            strobe  <= STROBE_INIT;
            key_out <= '0;
        end else begin
            key_out <= strobe;
            if ($onehot(strobe)) begin
                strobe <= {strobe[SCAN_WIDTH-2:0], strobe[SCAN_WIDTH-1]};  // Next column
            end else begin
                strobe <= STROBE_INIT;  // Recover from upset
            end
        end
    end

endmodule

/* hw/keypad_pkg.sv */
package keypad_pkg;

    // 4x4 matrix, one column strobe, four row lines
    localparam int SCAN_WIDTH = 4;

    // Key index fits 0..16
    localparam int KEY_WIDTH = 5;

    localparam int LED_WIDTH = 5;

    // All segments off when no key is seen
    localparam logic [LED_WIDTH-1:0] LED_IDLE = 5'd31;

    // Index = 4 * column position + row position + 1
    // LED code of a key is LED_IDLE minus its index
    typedef enum logic [KEY_WIDTH-1:0] {
        K_NONE = 5'd0,
        K_1    = 5'd1,   // Col 0
        K_2    = 5'd2,
        K_3    = 5'd3,
        K_MUL  = 5'd4,
        K_4    = 5'd5,   // Col 1
        K_5    = 5'd6,
        K_6    = 5'd7,
        K_Y    = 5'd8,
        K_7    = 5'd9,   // Col 2
        K_8    = 5'd10,
        K_9    = 5'd11,
        K_CLR  = 5'd12,
        K_0    = 5'd13,  // Col 3
        K_ADD  = 5'd14,
        K_SUB  = 5'd15,
        K_EQ   = 5'd16
    } key_e;

endpackage

/* src.f */
hw/keypad_pkg.sv
hw/calc_pkg.sv
hw/key_scanner.sv
hw/key_decoder.sv
hw/calc_fsm.sv
hw/bcd_splitter.sv
hw/calculator_top.sv
verif/calculator_asserts.sv
verif/calculator_tb.sv

/* verif/calculator_asserts.sv */
`timescale 1ns/1ns

module calculator_asserts (
    input logic                              time1Oms,
    input logic                              reset,
    input logic [keypad_pkg::SCAN_WIDTH-1:0] key_out,
    input logic                              point_time,
    input logic [calc_pkg::DIGIT_WIDTH-1:0]  led_sign
);

    import calc_pkg::*;

    logic scan_started;  // First edge after reset seen

    always_ff @(posedge time1Oms or negedge reset) begin
        if (!reset) begin
            scan_started <= 1'b0;
        end else begin
            scan_started <= 1'b1;
        end
    end

    scan_onehot: assert property (@(posedge time1Oms) disable iff (!reset)
        scan_started |-> $onehot(key_out))
        else $error("key_out not one-hot: %b", key_out);

    sign_code: assert property (@(posedge time1Oms) disable iff (!reset)
        led_sign == SIGN_BLANK || led_sign == SIGN_MINUS)
        else $error("led_sign holds code %0d", led_sign);

    point_after_reset: assert property (@(posedge time1Oms) $rose(reset) |-> point_time)
        else $error("point_time low after reset");

endmodule

// Scanner output and FSM outputs both meet at the top level
bind calculator_top calculator_asserts asserts_inst (
    .time1Oms   (time1Oms),
    .reset      (reset),
    .key_out    (key_out),
    .point_time (point_time),
    .led_sign   (led_sign)
);

/* verif/calculator_tb.sv */
`timescale 1ns/1ns

module calculator_tb;

    import keypad_pkg::*;
    import calc_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 4;
    localparam int PRESS_CYCLES = 8;   // 4 held, 4 idle
    localparam int N_LED        = 16;
    localparam int N_ADD        = 6;
    localparam int N_SUB        = 4;
    localparam int N_MUL        = 6;
    localparam int N_MISC       = 13;
    // Each pair is digit, operator, digit, equals; one extra 9 x 9 pair
    localparam int N_PRESSES    = N_LED + 4 * (N_ADD + N_SUB + N_MUL + 1) + N_MISC;
    localparam int CYCLE_LIMIT  = N_PRESSES * PRESS_CYCLES + 200;

    localparam int SUB_A [N_SUB] = '{7, 2, 5, 0};
    localparam int SUB_B [N_SUB] = '{3, 8, 5, 9};

    localparam key_e MISC_KEYS [N_MISC] = '{
        K_4, K_ADD, K_CLR,                  // Clear in the middle of entry
        K_3, K_7, K_ADD, K_2, K_EQ,         // Second digit for A dropped
        K_SUB, K_6, K_Y, K_EQ, K_CLR        // Early operator, Y, bare equals
    };

    logic                   time1Oms;
    logic                   reset;
    logic [SCAN_WIDTH-1:0]  key_in;
    logic [SCAN_WIDTH-1:0]  key_out;
    logic [LED_WIDTH-1:0]   led;
    logic                   point_time;
    logic [DIGIT_WIDTH-1:0] led_sign;
    logic [DIGIT_WIDTH-1:0] led_tens;
    logic [DIGIT_WIDTH-1:0] led_ones;

    key_e   active_key;
    integer seed;
    int     cycles;
    int     checks;
    int     errors;
    int     test_errors;
    string  test_name;
    event   compare_ev;

    // Reference model state
    calc_state_e            m_state;
    calc_op_e               m_op;
    int                     m_a;
    int                     m_b;
    int                     m_result;
    logic                   m_point;
    logic [DIGIT_WIDTH-1:0] m_sign;

    logic [DIGIT_WIDTH-1:0] exp_sign;
    logic [DIGIT_WIDTH-1:0] exp_tens;
    logic [DIGIT_WIDTH-1:0] exp_ones;
    logic                   exp_point;

    calculator_top calculator_inst (
        .time1Oms   (time1Oms),
        .reset      (reset),
        .key_in     (key_in),
        .key_out    (key_out),
        .led        (led),
        .point_time (point_time),
        .led_sign   (led_sign),
        .led_tens   (led_tens),
        .led_ones   (led_ones)
    );

    initial begin
        time1Oms = 1'b0;
        forever #CLK_HALF time1Oms = ~time1Oms;
    end

    function automatic logic [SCAN_WIDTH-1:0] rotate_strobe(input logic [SCAN_WIDTH-1:0] v);
        return {v[SCAN_WIDTH-2:0], v[SCAN_WIDTH-1]};
    endfunction

    // Column and row of a key from its index
    function automatic logic [SCAN_WIDTH-1:0] col_mask(input key_e k);
        return SCAN_WIDTH'(1) << ((int'(k) - 1) / 4);
    endfunction

    function automatic logic [SCAN_WIDTH-1:0] row_mask(input key_e k);
        return SCAN_WIDTH'(1) << ((int'(k) - 1) % 4);
    endfunction

    // Keypad matrix: row closes only while its column is strobed
    initial begin
        key_in = '0;
        forever begin
            @(posedge time1Oms);
            if (active_key != K_NONE && rotate_strobe(key_out) == col_mask(active_key)) begin
                key_in <= row_mask(active_key);
            end else begin
                key_in <= '0;
            end
        end
    end

    function automatic key_e digit_key(input int d);
        case (d)
            0:       return K_0;
            1:       return K_1;
            2:       return K_2;
            3:       return K_3;
            4:       return K_4;
            5:       return K_5;
            6:       return K_6;
            7:       return K_7;
            8:       return K_8;
            9:       return K_9;
            default: return K_NONE;
        endcase
    endfunction

    function automatic int key_value(input key_e k);
        case (k)
            K_0:     return 0;
            K_1:     return 1;
            K_2:     return 2;
            K_3:     return 3;
            K_4:     return 4;
            K_5:     return 5;
            K_6:     return 6;
            K_7:     return 7;
            K_8:     return 8;
            K_9:     return 9;
            default: return -1;
        endcase
    endfunction

    function automatic int rand_digit();
        return $unsigned($random(seed)) % 10;
    endfunction

    function automatic void model_reset();
        m_state  = S_ENTER_A;
        m_op     = OP_NONE;
        m_a      = 0;
        m_b      = 0;
        m_result = 0;
        m_point  = 1'b1;
        m_sign   = SIGN_BLANK;
    endfunction

    function automatic void update_expected();
        exp_sign  = m_sign;
        exp_tens  = DIGIT_WIDTH'(m_result / 10);
        exp_ones  = DIGIT_WIDTH'(m_result % 10);
        exp_point = m_point;
    endfunction

    function automatic void calc_ref(input key_e k);
        int d;
        d = key_value(k);
        if (d >= 0) begin
            if (m_state == S_ENTER_A) begin
                m_a      = d;
                m_result = d;
                m_sign   = SIGN_BLANK;
                m_state  = S_HAVE_A;
            end else if (m_state == S_ENTER_B) begin
                m_b      = d;
                m_result = d;
                m_state  = S_HAVE_B;
            end
        end else if (k == K_ADD || k == K_SUB || k == K_MUL) begin
            if (m_state == S_HAVE_A) begin
                m_state = S_ENTER_B;
                m_point = (k == K_ADD);
                m_op    = (k == K_ADD) ? OP_ADD : (k == K_SUB) ? OP_SUB : OP_MUL;
            end
        end else if (k == K_EQ) begin
            case (m_op)
                OP_ADD: begin
                    m_result = m_a + m_b;
                    m_sign   = SIGN_BLANK;
                end
                OP_SUB: begin
                    m_result = (m_a >= m_b) ? m_a - m_b : m_b - m_a;
                    m_sign   = (m_a >= m_b) ? SIGN_BLANK : SIGN_MINUS;
                end
                OP_MUL: begin
                    m_result = m_a * m_b;
                    m_sign   = SIGN_BLANK;
                end
                default: ;
            endcase
            m_point = 1'b1;
            m_op    = OP_NONE;
            m_state = S_ENTER_A;
        end else if (k == K_CLR) begin
            model_reset();
        end
        update_expected();
    endfunction

    task automatic record_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_key_out(input logic [SCAN_WIDTH-1:0] got,
                                 input logic [SCAN_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR key_out got 0x%0h expected 0x%0h", got, exp);
            record_error();
        end
    endtask

    task automatic check_led(input logic [LED_WIDTH-1:0] got, input logic [LED_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR led got 0x%0h expected 0x%0h", got, exp);
            record_error();
        end
    endtask

    task automatic check_display(input string name, input logic [DIGIT_WIDTH-1:0] got,
                                 input logic [DIGIT_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            record_error();
        end
    endtask

    task automatic check_point(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERR point_time got 0x%0h expected 0x%0h", got, exp);
            record_error();
        end
    endtask

    // Display comparison against the reference model
    initial begin
        forever begin
            @(compare_ev);
            check_display("led_sign", led_sign, exp_sign);
            check_display("led_tens", led_tens, exp_tens);
            check_display("led_ones", led_ones, exp_ones);
            check_point(point_time, exp_point);
        end
    end

    task automatic press_key(input key_e k);
        int                   hit_at;
        int                   led_at;
        logic [LED_WIDTH-1:0] led_seen;
        hit_at   = -1;
        led_at   = -1;
        led_seen = LED_IDLE;
        for (int i = 0; i < PRESS_CYCLES; i++) begin
            @(posedge time1Oms);
            if (i == 0) begin
                active_key <= k;
            end
            if (i == 4) begin
                active_key <= K_NONE;  // Release
            end
            @(negedge time1Oms);
            if (key_in != '0 && hit_at < 0) begin
                hit_at = i;
            end
            if (led != LED_IDLE && led_at < 0) begin
                led_at   = i;
                led_seen = led;
            end
        end
        if (hit_at < 0) begin
            $display("Key %s was never seen on the row lines", k.name());
            record_error();
        end else if (led_at < 0) begin
            $display("LED never showed a code for key %s", k.name());
            record_error();
        end else if (led_at != hit_at + 1) begin
            $display("LED for key %s came %0d cycles after its strobe instead of 1",
                     k.name(), led_at - hit_at);
            record_error();
        end
        check_led(led_seen, LED_WIDTH'(31 - int'(k)));
        check_led(led, LED_IDLE);
        calc_ref(k);
        -> compare_ev;
    endtask

    task automatic run_pair(input int a, input key_e op, input int b);
        press_key(digit_key(a));
        press_key(op);
        press_key(digit_key(b));
        press_key(K_EQ);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        #1;  // Let the last comparison finish
        $display("test %-16s %0d errors", test_name, test_errors);
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge time1Oms);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Run stopped after %0d cycles without finishing the tests", cycles);
                $display("*** TEST FAILED ***");
                $finish;
            end
        end
    end

    initial begin
        reset       = 1'b0;
        active_key  = K_NONE;
        seed        = 11294;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        model_reset();
        update_expected();
        repeat (RESET_CYCLES) @(posedge time1Oms);
        reset <= 1'b1;

        begin_test("reset_scan");
        @(negedge time1Oms);
        -> compare_ev;
        check_led(led, LED_IDLE);
        check_key_out(key_out, '0);
        for (int i = 0; i < 2 * SCAN_WIDTH; i++) begin
            @(negedge time1Oms);
            check_key_out(key_out, SCAN_WIDTH'(1) << (i % SCAN_WIDTH));  // Column i mod 4
        end
        end_test();

        begin_test("led_codes");
        for (int i = 1; i <= N_LED; i++) begin
            press_key(key_e'(i));
        end
        end_test();

        begin_test("addition");
        for (int i = 0; i < N_ADD; i++) begin
            run_pair(rand_digit(), K_ADD, rand_digit());
        end
        end_test();

        begin_test("subtraction");
        for (int i = 0; i < N_SUB; i++) begin
            run_pair(SUB_A[i], K_SUB, SUB_B[i]);
        end
        end_test();

        begin_test("multiplication");
        for (int i = 0; i < N_MUL; i++) begin
            run_pair(rand_digit(), K_MUL, rand_digit());
        end
        run_pair(9, K_MUL, 9);  // Largest product
        end_test();

        begin_test("clear_ignored");
        for (int i = 0; i < N_MISC; i++) begin
            press_key(MISC_KEYS[i]);
        end
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
